/* bench/outputPortTable.svh */
`ifndef OUTPUT_PORT_TABLE_SVH
`define OUTPUT_PORT_TABLE_SVH

// one row per test, lengths packed as {S, W, E, N, L}
// drop and header columns use -1 when the row has no such event
localparam int NUM_TESTS = 5;

string    tName [NUM_TESTS];
portVec   tReq [NUM_TESTS];      // request mask held from cycle 0
logic [`NUM_PORTS-1:0][`LENGTH_W-1:0] tLen [NUM_TESTS];
int       tHold [NUM_TESTS];     // cycles before all requests drop
portVec   tDropMask [NUM_TESTS];
int       tDropAt [NUM_TESTS];
portVec   tHdrMask [NUM_TESTS];  // ports that get a second header
int       tHdrAt [NUM_TESTS];
pktLength tNewLen [NUM_TESTS];
string    tSeq [NUM_TESTS];      // expected grant order, one letter per grant

task automatic setRow(input int i, input string name, input portVec r,
                      input logic [`NUM_PORTS-1:0][`LENGTH_W-1:0] lens, input int hold,
                      input portVec dropMask, input int dropAt, input portVec hdrMask,
                      input int hdrAt, input pktLength newLen, input string seq);
  tName[i] = name;
  tReq[i] = r;
  tLen[i] = lens;
  tHold[i] = hold;
  tDropMask[i] = dropMask;
  tDropAt[i] = dropAt;
  tHdrMask[i] = hdrMask;
  tHdrAt[i] = hdrAt;
  tNewLen[i] = newLen;
  tSeq[i] = seq;
endtask

task automatic loadTable();
  setRow(0, "single_N", 5'b00010, {12'd2, 12'd2, 12'd2, 12'd2, 12'd2}, 4,
         5'b00000, -1, 5'b00000, -1, 12'd0, "N");
  setRow(1, "all_five", 5'b11111, {12'd0, 12'd1, 12'd2, 12'd0, 12'd1}, 10,
         5'b00000, -1, 5'b00000, -1, 12'd0, "LNEWSL");
  setRow(2, "early_drop", 5'b00101, {12'd5, 12'd5, 12'd5, 12'd5, 12'd5}, 6,
         5'b00001, 2, 5'b00000, -1, 12'd0, "LE");
  setRow(3, "west_to_idle", 5'b01000, {12'd7, 12'd7, 12'd7, 12'd7, 12'd7}, 5,
         5'b01000, 3, 5'b00000, -1, 12'd0, "W");
  setRow(4, "new_header", 5'b10001, {12'd0, 12'd0, 12'd0, 12'd0, 12'd1}, 9,
         5'b00000, -1, 5'b10000, 1, 12'd3, "LSLS");
endtask

`endif

/* bench/outputPortTb.sv */
`timescale 1ns/10ps
`include "router_config.svh"

module outputPortTb;
  import routerPkg::*;

  `include "outputPortTable.svh"

  logic      clk = 1'b0;
  logic      rst;
  flit_t     inFlit [`NUM_PORTS];
  portVec    req;
  flit_t     outFlit;
  logic      outValid;
  grantState state;

  logic [16:0] lfsrState;
  int        cycleCount = 0;
  int        cycleLimit = 100000;
  int        errors = 0;
  int        testErrors;
  int        failedTests = 0;
  string     seq;
  grantState lastState;

  // the reference model keeps the owner's port index, or -1 when idle
  int        mOwner;
  int        mCount;
  pktLength  mLen [`NUM_PORTS];
  grantState expState;
  logic      expValid;
  flit_t     expFlit;

  always #4 clk = ~clk;

  outputPort i_outputPort
  (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .req      (req),
    .outFlit  (outFlit),
    .outValid (outValid),
    .state    (state)
  );

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > cycleLimit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  // x^17 + x^14 + 1
  function automatic logic nextBit();
    logic b;
    b = lfsrState[16] ^ lfsrState[13];
    lfsrState = {lfsrState[15:0], b};
    return b;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], nextBit()};
    end
    return v;
  endfunction

  function automatic string letterOf(input grantState s);
    case (s)
      GRANT_L: return "L";
      GRANT_N: return "N";
      GRANT_E: return "E";
      GRANT_W: return "W";
      GRANT_S: return "S";
      default: return "?";
    endcase
  endfunction

  // predicts the outputs after the coming clock edge from the inputs now driven
  task automatic modelStep();
    int nextOwner;
    logic [5:0] oneHot;
    nextOwner = -1;
    expValid = (mOwner >= 0) && req[mOwner];
    if (expValid)
    begin
      expFlit = inFlit[mOwner];
    end
    if (mOwner >= 0 && req[mOwner] && mCount != int'(mLen[mOwner]))
    begin
      nextOwner = mOwner;
      mCount++;
    end
    else
    begin
      mCount = 0;
      for (int k = (mOwner < 0) ? 0 : 1; k < `NUM_PORTS; k++)
      begin
        if (nextOwner < 0 && req[(mOwner + k + (mOwner < 0 ? 1 : 0)) % `NUM_PORTS])
        begin
          nextOwner = (mOwner + k + (mOwner < 0 ? 1 : 0)) % `NUM_PORTS;
        end
      end
    end
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (inFlit[p].id == `HEADER_ID)
      begin
        mLen[p] = inFlit[p].length;
      end
    end
    mOwner = nextOwner;
    oneHot = 6'b000010 << mOwner;
    expState = (mOwner < 0) ? IDLE : grantState'(oneHot);
  endtask

  task automatic stepCycle(input int t);
    modelStep();
    @(posedge clk);
    @(negedge clk);
    assert (state === expState) else
    begin
      $display("error %s: state expected %b actual %b", tName[t], expState, state);
      testErrors++;
    end
    assert (outValid === expValid) else
    begin
      $display("error %s: outValid expected %b actual %b", tName[t], expValid, outValid);
      testErrors++;
    end
    if (expValid)
    begin
      assert (outFlit === expFlit) else
      begin
        $display("error %s: outFlit expected %h actual %h", tName[t], expFlit, outFlit);
        testErrors++;
      end
    end
    if (state != IDLE && state != lastState)
    begin
      seq = {seq, letterOf(state)};
    end
    lastState = state;
  endtask

  task automatic runTest(input int t);
    logic header;
    int n;
    testErrors = 0;
    seq = "";
    lastState = IDLE;
    for (int c = 0; c < tHold[t]; c++)
    begin
      req = tReq[t];
      if (tDropAt[t] >= 0 && c >= tDropAt[t])
      begin
        req = req & ~tDropMask[t];
      end
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        header = (c == 0) || (c == tHdrAt[t] && tHdrMask[t][p]);
        inFlit[p].id = header ? `HEADER_ID : 3'd0;
        inFlit[p].length = (c == 0) ? tLen[t][p] : header ? tNewLen[t] : pktLength'(randBits(12));
        inFlit[p].data = payload'(randBits(16));
      end
      stepCycle(t);
    end
    req = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inFlit[p].id = 3'd0;
    end
    n = 0;
    while ((mOwner >= 0 || expValid) && n < 10)
    begin
      stepCycle(t);
      n++;
    end
    assert (state === IDLE) else
    begin
      $display("%s: the arbiter did not return to idle after all requests dropped", tName[t]);
      testErrors++;
    end
    assert (seq == tSeq[t]) else
    begin
      $display("error %s: grant order expected %s actual %s", tName[t], tSeq[t], seq);
      testErrors++;
    end
    $display("test %s: %s (%0d errors)", tName[t], testErrors == 0 ? "ok" : "FAIL", testErrors);
    errors += testErrors;
    if (testErrors != 0)
    begin
      failedTests++;
    end
  endtask

  initial
  begin
    loadTable();
    cycleLimit = 100;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      cycleLimit += 2 * (tHold[t] + 10);
    end
    cycleLimit += 8; // reset and settling
    lfsrState = 17'd99973;
    rst = 1'b1;
    req = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inFlit[p] = '0;
    end
    mOwner = -1;
    mCount = 0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      mLen[p] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (state === IDLE && outValid === 1'b0) else
    begin
      $display("after reset the arbiter is not idle or outValid is high");
      errors++;
    end
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      runTest(t);
    end
    $display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failedTests, errors);
    if (errors == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* hdl/flitSwitch.sv */
`timescale 1ns/10ps
`include "router_config.svh"

module flitSwitch
(
  input  logic                 clk,
  input  logic                 rst,
  input  routerPkg::grantState state,
  input  routerPkg::portVec    req,
  input  routerPkg::flit_t     inFlit [`NUM_PORTS],
  output routerPkg::flit_t     outFlit,
  output logic                 outValid
);
  import routerPkg::*;

  flit_t selFlit;
  logic  selValid;

  always_comb
  begin
    selFlit = inFlit[0];
    selValid = 1'b0;
    case (state)
      GRANT_L:
      begin
        selFlit = inFlit[0];
        selValid = req[0];
      end
      GRANT_N:
      begin
        selFlit = inFlit[1];
        selValid = req[1];
      end
      GRANT_E:
      begin
        selFlit = inFlit[2];
        selValid = req[2];
      end
      GRANT_W:
      begin
        selFlit = inFlit[3];
        selValid = req[3];
      end
      GRANT_S:
      begin
        selFlit = inFlit[4];
        selValid = req[4];
      end
      default:
      begin
        selValid = 1'b0; // idle, nothing goes out
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= selValid;
    end
  end

  // the flit register keeps its last value while nothing is forwarded
  always_ff @(posedge clk)
  begin
    if (selValid)
    begin
      outFlit <= selFlit;
    end
  end

endmodule

/* hdl/outputArbiter.sv */
`timescale 1ns/10ps
`include "router_config.svh"

module outputArbiter
(
  input  logic                 clk,
  input  logic                 rst,
  input  routerPkg::portVec    req,
  input  routerPkg::portVec    timesUp,
  output routerPkg::grantState state,
  output routerPkg::portVec    runTimer
);
  import routerPkg::*;

  localparam int PORT_W = $clog2(`NUM_PORTS);

  grantState nextState;
  logic [PORT_W-1:0] owner; // port index of the current grant
  logic ownerHolds;

  // one-hot grant code for a port index
  function automatic grantState grantFor(input int idx);
    logic [$bits(grantState)-1:0] oneHot;
    oneHot = '0;
    oneHot[idx+1] = 1'b1;
    return grantState'(oneHot);
  endfunction

  // port index of a grant state, zero for idle
  function automatic logic [PORT_W-1:0] ownerOf(input grantState cur);
    logic [PORT_W-1:0] idx;
    idx = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (cur[p+1])
      begin
        idx = PORT_W'(p);
      end
    end
    return idx;
  endfunction

  // first requester among span ports starting at port first, wrapping after S
  function automatic grantState pickNext(input portVec reqs, input int first,
                                         input int span);
    grantState pick;
    int idx;
    pick = IDLE;
    // scanned from the far end so the nearest requester is written last
    for (int k = span - 1; k >= 0; k--)
    begin
      idx = (first + k) % `NUM_PORTS;
      if (reqs[idx])
      begin
        pick = grantFor(idx);
      end
    end
    return pick;
  endfunction

  assign owner = ownerOf(state);

  // the owner keeps the output while it asks and its packet time is not used up
  assign ownerHolds = req[owner] && !timesUp[owner];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    nextState = IDLE;
    runTimer = '0;
    case (state)
      IDLE:
      begin
        nextState = pickNext(req, 0, `NUM_PORTS); // fixed order L, N, E, W, S
      end
      GRANT_L, GRANT_N, GRANT_E, GRANT_W, GRANT_S:
      begin
        if (ownerHolds)
        begin
          runTimer[owner] = 1'b1;
          nextState = state;
        end
        else
        begin
          // the releasing port itself is not a candidate, so it waits one idle turn
          nextState = pickNext(req, int'(owner) + 1, `NUM_PORTS - 1);
        end
      end
      default:
      begin
        nextState = IDLE; // recover from a state that is not one-hot
      end
    endcase
  end

endmodule

/* hdl/outputPort.sv */
`timescale 1ns/10ps
`include "router_config.svh"

module outputPort
(
  input  logic                 clk,
  input  logic                 rst,
  input  routerPkg::flit_t     inFlit [`NUM_PORTS],
  input  routerPkg::portVec    req,
  output routerPkg::flit_t     outFlit,
  output logic                 outValid,
  output routerPkg::grantState state
);
  import routerPkg::*;

  portVec runTimer; // set only for the port that keeps its grant
  portVec timesUp;

  // one packet timer per input port
  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : g_timer
    packetTimer i_packetTimer
    (
      .clk     (clk),
      .rst     (rst),
      .id      (inFlit[p].id),
      .length  (inFlit[p].length),
      .run     (runTimer[p]),
      .timesUp (timesUp[p])
    );
  end

  outputArbiter i_outputArbiter
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .state    (state),
    .runTimer (runTimer)
  );

  // forwards the owner's flit one cycle behind the grant state
  flitSwitch i_flitSwitch
  (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .req      (req),
    .inFlit   (inFlit),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

/* hdl/packetTimer.sv */
`timescale 1ns/10ps
`include "router_config.svh"

module packetTimer
(
  input  logic                clk,
  input  logic                rst,
  input  routerPkg::flitId    id,
  input  routerPkg::pktLength length,
  input  logic                run,
  output logic                timesUp
);
  import routerPkg::*;

  pktLength storedLength; // hold time learned from the last header flit
  pktLength count;        // cycles the port has held the output so far

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      storedLength <= '0;
      count <= '0;
    end
    else
    begin
      // a header may arrive while another port owns the output
      if (id == `HEADER_ID)
      begin
        storedLength <= length;
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0; // restart for the next grant
      end
    end
  end

  assign timesUp = (count == storedLength);

endmodule

/* hdl/routerPkg.sv */
`include "router_config.svh"

package routerPkg;

  // flit type, header or body/tail
  typedef logic [`FLIT_ID_W-1:0] flitId;

  typedef logic [`LENGTH_W-1:0] pktLength; // packet length in clock cycles
  typedef logic [`PAYLOAD_W-1:0] payload;

  // one bit per port, L=0 N=1 E=2 W=3 S=4
  typedef logic [`NUM_PORTS-1:0] portVec;

  typedef struct packed
  {
    flitId    id;
    pktLength length;
    payload   data;
  } flit_t;

  // bit 0 is idle, bit p+1 is the grant for port p
  typedef enum logic [5:0]
  {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } grantState;

endpackage

/* hdl/router_config.svh */
`ifndef ROUTER_CONFIG_SVH
`define ROUTER_CONFIG_SVH

// ports of the mesh router, in the order L, N, E, W, S
`define NUM_PORTS 5

// flit fields
`define FLIT_ID_W 3
`define LENGTH_W 12
`define PAYLOAD_W 16

// flit id that opens a packet and carries its length
`define HEADER_ID 3'd1

`endif

/* run.sh */
#!/bin/sh
# Compile and run the output port testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module outputPortTb -Mdir obj_dir

output=$(./obj_dir/VoutputPortTb)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi

/* vlog.f */
+incdir+hdl
+incdir+bench
hdl/routerPkg.sv
hdl/packetTimer.sv
hdl/outputArbiter.sv
hdl/flitSwitch.sv
hdl/outputPort.sv
bench/outputPortTb.sv
